// ==== include/btc_enc_params.svh ====
`ifndef BTC_ENC_PARAMS_SVH
`define BTC_ENC_PARAMS_SVH

// largest component code length
`define BTC_MAX_N       64

// row / column index width, log2 of BTC_MAX_N
`define BTC_IDX_W       6

// input FIFO depth, also the source credits after reset
`define BTC_IN_CREDITS  4

// beats the scheduler may send before any credit comes back
`define BTC_OUT_CREDITS 8

`endif

// ==== logic/btc_enc_pkg.sv ====
`include "btc_enc_params.svh"

package btc_enc_pkg;

  // component code size, n = 8 << size
  typedef enum logic [1:0] {
    cBSIZE_8,
    cBSIZE_16,
    cBSIZE_32,
    cBSIZE_64
  } btc_bsize_t;

  typedef enum logic {
    cCODE_SPC,
    cCODE_EHAM
  } btc_code_t;

  typedef struct packed {
    btc_bsize_t size;
    btc_code_t  code;
  } btc_code_mode_t;

  // one beat of a bit-serial codeword
  typedef struct packed {
    logic sop;
    logic eop;
    logic eof;
    logic dat;
  } btc_beat_t;

  // hamming remainder, low log2(n) bits used
  typedef logic [7:0] state_t;

  // generator polynomials without the top term
  localparam state_t cPRIM_POLY_8  = 8'h03;
  localparam state_t cPRIM_POLY_16 = 8'h03;
  localparam state_t cPRIM_POLY_32 = 8'h05;
  localparam state_t cPRIM_POLY_64 = 8'h03;

  typedef enum logic [1:0] {
    WAIT_BANK,
    INFO_SLOT,
    CODE_SLOT
  } btc_framer_state_t;

  typedef enum logic {
    IDLE,
    COLUMN
  } btc_sched_state_t;

  // n - 1
  function automatic logic [`BTC_IDX_W-1:0] btc_n_last(input btc_code_mode_t m);
    return `BTC_IDX_W'((8 << m.size) - 1);
  endfunction

  // k - 1, eham drops log2(n) more bits than spc
  function automatic logic [`BTC_IDX_W-1:0] btc_k_last(input btc_code_mode_t m);
    logic [`BTC_IDX_W-1:0] n_last;
    n_last = btc_n_last(m);
    if (m.code == cCODE_SPC) begin
      return n_last - 1'b1;
    end
    return n_last - `BTC_IDX_W'(4 + m.size);
  endfunction

endpackage

// ==== logic/btc_enc_comp_code.sv ====
`timescale 1ns/1ps

module btc_enc_comp_code (
  input  logic                        iclk,
  input  logic                        ireset,
  input  btc_enc_pkg::btc_code_mode_t imode,
  input  logic                        ival,
  input  btc_enc_pkg::btc_beat_t      ibeat,
  output logic                        oval,
  output btc_enc_pkg::btc_beat_t      obeat
);

  import btc_enc_pkg::*;

  state_t poly;
  state_t rem;
  logic   rem_msb;
  logic   parity;
  logic   info_phase;

  // --------------------
  // polynomial select
  // --------------------

  always_comb begin
    case (imode.size)
      cBSIZE_16: begin
        poly    = cPRIM_POLY_16;
        rem_msb = rem[3];
      end
      cBSIZE_32: begin
        poly    = cPRIM_POLY_32;
        rem_msb = rem[4];
      end
      cBSIZE_64: begin
        poly    = cPRIM_POLY_64;
        rem_msb = rem[5];
      end
      default: begin
        poly    = cPRIM_POLY_8;
        rem_msb = rem[2];
      end
    endcase
  end

  // --------------------
  // remainder and parity
  // --------------------

  always_ff @(posedge iclk) begin
    if (ival) begin
      // info phase runs from sop through eop
      if (ibeat.sop) begin
        info_phase <= 1'b1;
      end else if (ibeat.eop) begin
        info_phase <= 1'b0;
      end
      if (ibeat.sop) begin
        // empty remainder, so feedback is the bit itself
        parity <= ibeat.dat;
        rem    <= {8{ibeat.dat}} & poly;
      end else if (info_phase) begin
        parity <= parity ^ ibeat.dat;
        rem    <= (rem << 1) ^ ({8{ibeat.dat ^ rem_msb}} & poly);
      end else begin
        // code slots shift the remainder out msb first
        parity <= parity ^ rem_msb;
        rem    <= rem << 1;
      end
    end
  end

  // --------------------
  // output beat
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    obeat.sop <= ival & ibeat.sop;
    obeat.eop <= ival & ibeat.eop;
    obeat.eof <= ival & ibeat.eof;
    if (ibeat.sop || info_phase) begin
      obeat.dat <= ibeat.dat;
    end else if (ibeat.eof) begin
      // overall even parity closes the codeword
      obeat.dat <= parity;
    end else begin
      obeat.dat <= rem_msb;
    end
  end

  // a codeword is always longer than one beat
  assert property (@(posedge iclk) disable iff (ireset)
    ival |-> !(ibeat.sop && ibeat.eof))
    else $error("comp code: sop and eof on one beat");

endmodule

// ==== logic/btc_enc_row_framer.sv ====
`timescale 1ns/1ps
`include "btc_enc_params.svh"

module btc_enc_row_framer (
  input  logic                        iclk,
  input  logic                        ireset,
  input  btc_enc_pkg::btc_code_mode_t mode,
  input  logic                        in_val,
  input  logic                        in_dat,
  output logic                        in_credit,
  input  logic                        wr_bank_free,
  output btc_enc_pkg::btc_code_mode_t row_mode,
  output logic                        row_val,
  output btc_enc_pkg::btc_beat_t      row_beat
);

  import btc_enc_pkg::*;

  localparam int DEPTH = `BTC_IN_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic                  fifo_mem [DEPTH];
  logic [PTR_W-1:0]      fifo_wr_ptr;
  logic [PTR_W-1:0]      fifo_rd_ptr;
  logic [CNT_W-1:0]      fifo_cnt;
  logic                  pop;
  logic                  issue;

  btc_framer_state_t     state;
  logic [`BTC_IDX_W-1:0] row_idx;
  logic [`BTC_IDX_W-1:0] slot_idx;
  logic [`BTC_IDX_W-1:0] n_last;
  logic [`BTC_IDX_W-1:0] k_last;

  // --------------------
  // input bit FIFO
  // --------------------

  always_ff @(posedge iclk) begin
    if (in_val) begin
      fifo_mem[fifo_wr_ptr] <= in_dat;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      fifo_wr_ptr <= '0;
      fifo_rd_ptr <= '0;
      fifo_cnt    <= '0;
      in_credit   <= 1'b0;
    end else begin
      fifo_wr_ptr <= fifo_wr_ptr + PTR_W'(in_val);
      fifo_rd_ptr <= fifo_rd_ptr + PTR_W'(pop);
      fifo_cnt    <= fifo_cnt + CNT_W'(in_val) - CNT_W'(pop);
      // one credit back per popped bit
      in_credit   <= pop;
    end
  end

  // --------------------
  // slot issue
  // --------------------

  always_comb begin
    n_last       = btc_n_last(row_mode);
    k_last       = btc_k_last(row_mode);
    // info slots wait for data, code slots go freely
    pop          = (state == INFO_SLOT) && (fifo_cnt != '0);
    issue        = pop || (state == CODE_SLOT);
    row_val      = issue;
    row_beat.sop = slot_idx == '0;
    row_beat.eop = slot_idx == k_last;
    row_beat.eof = slot_idx == n_last;
    row_beat.dat = fifo_mem[fifo_rd_ptr];
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= WAIT_BANK;
      row_mode <= '{size: cBSIZE_8, code: cCODE_SPC};
      row_idx  <= '0;
      slot_idx <= '0;
    end else begin
      case (state)
        WAIT_BANK: begin
          // mode sampled once per frame
          if (wr_bank_free) begin
            row_mode <= mode;
            row_idx  <= '0;
            slot_idx <= '0;
            state    <= INFO_SLOT;
          end
        end
        INFO_SLOT: begin
          if (issue) begin
            slot_idx <= slot_idx + 1'b1;
            if (slot_idx == k_last) begin
              state <= CODE_SLOT;
            end
          end
        end
        CODE_SLOT: begin
          if (slot_idx == n_last) begin
            slot_idx <= '0;
            row_idx  <= row_idx + 1'b1;
            state    <= INFO_SLOT;
            // k rows make a frame
            if (row_idx == k_last) begin
              row_idx <= '0;
              state   <= WAIT_BANK;
            end
          end else begin
            slot_idx <= slot_idx + 1'b1;
          end
        end
        default: state <= WAIT_BANK;
      endcase
    end
  end

  // source sends only against a held credit
  assert property (@(posedge iclk) disable iff (ireset)
    in_val |-> (fifo_cnt < CNT_W'(DEPTH)))
    else $error("row framer: input FIFO overflow");

endmodule

// ==== logic/btc_enc_frame_buf.sv ====
`timescale 1ns/1ps
`include "btc_enc_params.svh"

module btc_enc_frame_buf (
  input  logic                        iclk,
  input  logic                        ireset,
  input  btc_enc_pkg::btc_code_mode_t wr_mode,
  input  logic                        wr_val,
  input  btc_enc_pkg::btc_beat_t      wr_beat,
  output logic                        wr_bank_free,
  output logic                        rd_ready,
  output btc_enc_pkg::btc_code_mode_t rd_mode,
  input  logic [`BTC_IDX_W-1:0]       rd_addr_row,
  input  logic [`BTC_IDX_W-1:0]       rd_addr_col,
  output logic                        rd_dat,
  input  logic                        rd_done
);

  import btc_enc_pkg::*;

  // bank, row, column
  localparam int AW = 1 + 2 * `BTC_IDX_W;

  logic                  mem [2 * `BTC_MAX_N * `BTC_MAX_N];
  btc_code_mode_t        bank_mode [2];
  logic [1:0]            bank_full;
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic                  wr_busy;
  logic                  frame_start;
  logic [`BTC_IDX_W-1:0] wr_row;
  logic [`BTC_IDX_W-1:0] wr_col;
  logic [`BTC_IDX_W-1:0] wr_col_now;
  logic [AW-1:0]         wr_addr;
  logic [AW-1:0]         rd_addr;

  always_comb begin
    // sop restarts the column count
    wr_col_now   = wr_beat.sop ? '0 : wr_col;
    frame_start  = wr_val && wr_beat.sop && !wr_busy;
    wr_addr      = {wr_ptr, wr_row, wr_col_now};
    rd_addr      = {rd_ptr, rd_addr_row, rd_addr_col};
    // busy covers the tail of a frame still in the row encoder
    wr_bank_free = !bank_full[wr_ptr] && !wr_busy;
    rd_ready     = bank_full[rd_ptr];
    rd_mode      = bank_mode[rd_ptr];
  end

  // --------------------
  // bank control
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bank_full <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      wr_busy   <= 1'b0;
      wr_row    <= '0;
      wr_col    <= '0;
    end else begin
      if (rd_done) begin
        bank_full[rd_ptr] <= 1'b0;
        rd_ptr            <= ~rd_ptr;
      end
      if (frame_start) begin
        wr_busy <= 1'b1;
      end
      if (wr_val) begin
        wr_col <= wr_col_now + 1'b1;
        if (wr_beat.eof) begin
          wr_row <= wr_row + 1'b1;
          // eof of row k-1 closes the bank
          if (wr_row == btc_k_last(bank_mode[wr_ptr])) begin
            wr_row            <= '0;
            wr_busy           <= 1'b0;
            bank_full[wr_ptr] <= 1'b1;
            wr_ptr            <= ~wr_ptr;
          end
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (frame_start) begin
      bank_mode[wr_ptr] <= wr_mode;
    end
  end

  // --------------------
  // bit storage
  // --------------------

  always_ff @(posedge iclk) begin
    if (wr_val) begin
      mem[wr_addr] <= wr_beat.dat;
    end
    rd_dat <= mem[rd_addr];
  end

  assert property (@(posedge iclk) disable iff (ireset)
    rd_done |-> rd_ready)
    else $error("frame buf: rd_done without a full bank");

endmodule

// ==== logic/btc_enc_col_sched.sv ====
`timescale 1ns/1ps
`include "btc_enc_params.svh"

module btc_enc_col_sched (
  input  logic                        iclk,
  input  logic                        ireset,
  input  logic                        rd_ready,
  input  btc_enc_pkg::btc_code_mode_t rd_mode,
  output logic [`BTC_IDX_W-1:0]       rd_addr_row,
  output logic [`BTC_IDX_W-1:0]       rd_addr_col,
  input  logic                        rd_dat,
  output logic                        rd_done,
  input  logic                        out_credit,
  output btc_enc_pkg::btc_code_mode_t col_mode,
  output logic                        col_val,
  output btc_enc_pkg::btc_beat_t      col_beat
);

  import btc_enc_pkg::*;

  localparam int CRD_W = $clog2(`BTC_OUT_CREDITS + 1);

  btc_sched_state_t      state;
  logic [`BTC_IDX_W-1:0] col_idx;
  logic [`BTC_IDX_W-1:0] slot_idx;
  logic [`BTC_IDX_W-1:0] n_last;
  logic [`BTC_IDX_W-1:0] k_last;
  logic [CRD_W-1:0]      credit_cnt;
  logic                  issue;
  logic                  last_slot;
  logic                  flag_sop;
  logic                  flag_eop;
  logic                  flag_eof;

  always_comb begin
    n_last      = btc_n_last(col_mode);
    k_last      = btc_k_last(col_mode);
    issue       = (state == COLUMN) && (credit_cnt != '0);
    last_slot   = slot_idx == n_last;
    rd_done     = issue && last_slot && (col_idx == n_last);
    // code slots read stale rows, the encoder drops that data
    rd_addr_row = slot_idx;
    rd_addr_col = col_idx;
    // flags lag one cycle to line up with the read data
    col_beat    = '{sop: flag_sop, eop: flag_eop, eof: flag_eof, dat: rd_dat};
  end

  // --------------------
  // column sequencing
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= IDLE;
      col_mode   <= '{size: cBSIZE_8, code: cCODE_SPC};
      col_idx    <= '0;
      slot_idx   <= '0;
      credit_cnt <= CRD_W'(`BTC_OUT_CREDITS);
      col_val    <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - CRD_W'(issue) + CRD_W'(out_credit);
      col_val    <= issue;
      case (state)
        IDLE: begin
          if (rd_ready) begin
            col_mode <= rd_mode;
            col_idx  <= '0;
            slot_idx <= '0;
            state    <= COLUMN;
          end
        end
        COLUMN: begin
          if (issue) begin
            slot_idx <= slot_idx + 1'b1;
            if (last_slot) begin
              slot_idx <= '0;
              col_idx  <= col_idx + 1'b1;
              // column n-1 ends the frame
              if (col_idx == n_last) begin
                state <= IDLE;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    flag_sop <= slot_idx == '0;
    flag_eop <= slot_idx == k_last;
    flag_eof <= last_slot;
  end

  // sink returns no more credits than beats it got
  assert property (@(posedge iclk) disable iff (ireset)
    credit_cnt <= CRD_W'(`BTC_OUT_CREDITS))
    else $error("col sched: credit counter overflow");

endmodule

// ==== logic/btc_enc_top.sv ====
`timescale 1ns/1ps
`include "btc_enc_params.svh"

module btc_enc_top (
  input  logic                        iclk,
  input  logic                        ireset,
  input  btc_enc_pkg::btc_code_mode_t mode,
  input  logic                        in_val,
  input  logic                        in_dat,
  output logic                        in_credit,
  output logic                        out_val,
  output btc_enc_pkg::btc_beat_t      out_beat,
  input  logic                        out_credit
);

  import btc_enc_pkg::*;

  // row side
  btc_code_mode_t        row_mode;
  logic                  row_val;
  btc_beat_t             row_beat;
  logic                  wr_val;
  btc_beat_t             wr_beat;
  logic                  wr_bank_free;

  // column side
  logic                  rd_ready;
  btc_code_mode_t        rd_mode;
  logic [`BTC_IDX_W-1:0] rd_addr_row;
  logic [`BTC_IDX_W-1:0] rd_addr_col;
  logic                  rd_dat;
  logic                  rd_done;
  btc_code_mode_t        col_mode;
  logic                  col_val;
  btc_beat_t             col_beat;

  btc_enc_row_framer row_framer (
    .iclk         (iclk),
    .ireset       (ireset),
    .mode         (mode),
    .in_val       (in_val),
    .in_dat       (in_dat),
    .in_credit    (in_credit),
    .wr_bank_free (wr_bank_free),
    .row_mode     (row_mode),
    .row_val      (row_val),
    .row_beat     (row_beat)
  );

  btc_enc_comp_code row_code (
    .iclk   (iclk),
    .ireset (ireset),
    .imode  (row_mode),
    .ival   (row_val),
    .ibeat  (row_beat),
    .oval   (wr_val),
    .obeat  (wr_beat)
  );

  btc_enc_frame_buf frame_buf (
    .iclk         (iclk),
    .ireset       (ireset),
    .wr_mode      (row_mode),
    .wr_val       (wr_val),
    .wr_beat      (wr_beat),
    .wr_bank_free (wr_bank_free),
    .rd_ready     (rd_ready),
    .rd_mode      (rd_mode),
    .rd_addr_row  (rd_addr_row),
    .rd_addr_col  (rd_addr_col),
    .rd_dat       (rd_dat),
    .rd_done      (rd_done)
  );

  btc_enc_col_sched col_sched (
    .iclk        (iclk),
    .ireset      (ireset),
    .rd_ready    (rd_ready),
    .rd_mode     (rd_mode),
    .rd_addr_row (rd_addr_row),
    .rd_addr_col (rd_addr_col),
    .rd_dat      (rd_dat),
    .rd_done     (rd_done),
    .out_credit  (out_credit),
    .col_mode    (col_mode),
    .col_val     (col_val),
    .col_beat    (col_beat)
  );

  btc_enc_comp_code col_code (
    .iclk   (iclk),
    .ireset (ireset),
    .imode  (col_mode),
    .ival   (col_val),
    .ibeat  (col_beat),
    .oval   (out_val),
    .obeat  (out_beat)
  );

endmodule

// ==== sim/tb_btc_enc.sv ====
`timescale 1ns/1ps
`include "btc_enc_params.svh"

module tb_btc_enc;

  import btc_enc_pkg::*;

  typedef bit bit_q_t [$];

  // one source bit and the frame mode it belongs to
  typedef struct packed {
    btc_code_mode_t mode;
    logic           dat;
  } src_item_t;

  localparam btc_code_mode_t mode_spc_8   = '{size: cBSIZE_8, code: cCODE_SPC};
  localparam btc_code_mode_t mode_eham_8  = '{size: cBSIZE_8, code: cCODE_EHAM};
  localparam btc_code_mode_t mode_spc_16  = '{size: cBSIZE_16, code: cCODE_SPC};
  localparam btc_code_mode_t mode_eham_16 = '{size: cBSIZE_16, code: cCODE_EHAM};
  localparam btc_code_mode_t mode_spc_32  = '{size: cBSIZE_32, code: cCODE_SPC};
  localparam btc_code_mode_t mode_eham_32 = '{size: cBSIZE_32, code: cCODE_EHAM};
  localparam btc_code_mode_t mode_eham_64 = '{size: cBSIZE_64, code: cCODE_EHAM};

  logic           iclk = 1'b0;
  logic           ireset;
  btc_code_mode_t mode;
  logic           in_val;
  logic           in_dat;
  logic           in_credit;
  logic           out_val;
  btc_beat_t      out_beat;
  logic           out_credit;

  // source and sink model state
  src_item_t src_q [$];
  btc_beat_t exp_q [$];
  string     test_name;
  int        src_credits;
  int        owed_credits;
  int        sink_gap;
  int        info_total;
  int        exp_total;
  int        credit_pulses;
  int        beats_rx;
  int        credits_ret;

  btc_enc_top uut (
    .iclk       (iclk),
    .ireset     (ireset),
    .mode       (mode),
    .in_val     (in_val),
    .in_dat     (in_dat),
    .in_credit  (in_credit),
    .out_val    (out_val),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  // 4 ns period
  always #2 iclk = ~iclk;

  // --------------------
  // failure reporting
  // --------------------

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  task automatic check_beat(input btc_beat_t expected, input btc_beat_t actual,
                            input string name);
    if (actual !== expected) begin
      $display("[ERROR] %s: beat %0d {sop,eop,eof,dat} expected %b, actual %b",
               name, beats_rx, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input int expected, input int actual, input string name,
                             input string what);
    if (actual != expected) begin
      $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input logic expected, input logic actual, input string name,
                           input string what);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %b, actual %b", name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  // --------------------
  // golden model
  // --------------------

  function automatic int code_n(input btc_code_mode_t md);
    return 8 << int'(md.size);
  endfunction

  // spc drops one bit, eham also drops log2(n)
  function automatic int code_k(input btc_code_mode_t md);
    int n;
    n = code_n(md);
    return (md.code == cCODE_SPC) ? n - 1 : n - 4 - int'(md.size);
  endfunction

  // full generator, top term included
  function automatic int gen_poly(input btc_code_mode_t md);
    case (md.size)
      cBSIZE_16: return 'b10011;
      cBSIZE_32: return 'b100101;
      cBSIZE_64: return 'b1000011;
      default:   return 'b1011;
    endcase
  endfunction

  function automatic bit_q_t encode_word(input btc_code_mode_t md, input bit_q_t info);
    bit_q_t cw;
    bit_q_t work;
    int     m;
    int     gen;
    bit     par;
    m   = 3 + int'(md.size);
    gen = gen_poly(md);
    cw  = info;
    if (md.code == cCODE_EHAM) begin
      // long division of info times x^m, first bit is the highest degree
      work = info;
      for (int j = 0; j < m; j++) begin
        work.push_back(1'b0);
      end
      for (int i = 0; i < info.size(); i++) begin
        if (work[i]) begin
          for (int j = 0; j <= m; j++) begin
            work[i + j] = work[i + j] ^ gen[m - j];
          end
        end
      end
      for (int j = 0; j < m; j++) begin
        cw.push_back(work[info.size() + j]);
      end
    end
    // even parity over everything before it
    par = 1'b0;
    foreach (cw[i]) begin
      par = par ^ cw[i];
    end
    cw.push_back(par);
    return cw;
  endfunction

  // one_hot below zero gives random info bits
  task automatic queue_frame(input btc_code_mode_t md, input int one_hot);
    bit        coded [`BTC_MAX_N][`BTC_MAX_N];
    bit_q_t    info;
    bit_q_t    cw;
    btc_beat_t beat;
    src_item_t item;
    int        n;
    int        k;
    n = code_n(md);
    k = code_k(md);
    item.mode = md;
    // rows in input order
    for (int r = 0; r < k; r++) begin
      info.delete();
      for (int c = 0; c < k; c++) begin
        if (one_hot >= 0) begin
          item.dat = (r * k + c) == one_hot;
        end else begin
          item.dat = ($urandom % 2) != 0;
        end
        src_q.push_back(item);
        info.push_back(item.dat);
      end
      cw = encode_word(md, info);
      for (int c = 0; c < n; c++) begin
        coded[r][c] = cw[c];
      end
    end
    info_total += k * k;
    // column codewords, column 0 first
    for (int c = 0; c < n; c++) begin
      info.delete();
      for (int r = 0; r < k; r++) begin
        info.push_back(coded[r][c]);
      end
      cw = encode_word(md, info);
      for (int i = 0; i < n; i++) begin
        beat.sop = i == 0;
        beat.eop = i == k - 1;
        beat.eof = i == n - 1;
        beat.dat = cw[i];
        exp_q.push_back(beat);
      end
    end
    exp_total += n * n;
  endtask

  // --------------------
  // source and sink
  // --------------------

  task automatic take_beat();
    btc_beat_t expected;
    beats_rx++;
    owed_credits++;
    // beats past the expected stream show up in the final beat total
    if (exp_q.size() > 0) begin
      expected = exp_q.pop_front();
      check_beat(expected, out_beat, test_name);
    end
    if (beats_rx > `BTC_OUT_CREDITS + credits_ret) begin
      report_error($sformatf("%s: %0d beats sent against %0d credits", test_name,
                             beats_rx, `BTC_OUT_CREDITS + credits_ret));
    end
  endtask

  task automatic step_cycle();
    src_item_t item;
    @(posedge iclk);
    // outputs read here still hold their values from before the edge
    if (in_credit) begin
      src_credits++;
      credit_pulses++;
    end
    if (out_val) begin
      take_beat();
    end
    // one bit per held credit
    if (src_credits > 0 && src_q.size() > 0) begin
      item = src_q.pop_front();
      in_val <= 1'b1;
      in_dat <= item.dat;
      mode   <= item.mode;
      src_credits--;
    end else begin
      in_val <= 1'b0;
    end
    // sink hands back credits for beats taken, sparse when gap > 1
    if (owed_credits > 0 && (sink_gap <= 1 || ($urandom % sink_gap) == 0)) begin
      out_credit <= 1'b1;
      owed_credits--;
      credits_ret++;
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  task automatic reset_dut(input btc_code_mode_t md);
    @(posedge iclk);
    ireset     <= 1'b1;
    mode       <= md;
    in_val     <= 1'b0;
    in_dat     <= 1'b0;
    out_credit <= 1'b0;
    repeat (16) @(posedge iclk);
    ireset <= 1'b0;
    src_q.delete();
    exp_q.delete();
    src_credits   = `BTC_IN_CREDITS;
    owed_credits  = 0;
    sink_gap      = 1;
    info_total    = 0;
    exp_total     = 0;
    credit_pulses = 0;
    beats_rx      = 0;
    credits_ret   = 0;
  endtask

  task automatic run_frames(input int limit);
    int cycles;
    cycles = 0;
    while (src_q.size() > 0 || exp_q.size() > 0) begin
      step_cycle();
      cycles++;
      if (cycles > limit) begin
        report_error($sformatf("%s: timed out after %0d cycles with %0d beats missing",
                               test_name, cycles, exp_q.size()));
      end
    end
    // short guard window for stray beats
    repeat (8) step_cycle();
    check_count(info_total, credit_pulses, test_name, "in_credit pulses");
    check_count(exp_total, beats_rx, test_name, "out_val beats");
  endtask

  task automatic run_one_frame(input string name, input btc_code_mode_t md,
                               input int one_hot, input int limit);
    test_name = name;
    reset_dut(md);
    queue_frame(md, one_hot);
    run_frames(limit);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_idle_after_reset();
    test_name = "idle after reset";
    reset_dut(mode_spc_8);
    for (int i = 0; i < 8; i++) begin
      step_cycle();
      check_bit(1'b0, out_val, test_name, "out_val");
      check_bit(1'b0, in_credit, test_name, "in_credit");
    end
    queue_frame(mode_spc_8, -1);
    run_frames(20000);
  endtask

  task automatic test_single_bit();
    // row 1, column 1 of the 4 by 4 info block
    run_one_frame("single bit eham 8", mode_eham_8, 5, 20000);
  endtask

  task automatic test_random_frames();
    run_one_frame("random spc 16", mode_spc_16, -1, 20000);
    run_one_frame("random eham 32", mode_eham_32, -1, 40000);
  endtask

  task automatic test_largest_frame();
    run_one_frame("random eham 64", mode_eham_64, -1, 60000);
  endtask

  task automatic test_back_to_back();
    test_name = "back to back";
    reset_dut(mode_eham_16);
    sink_gap = 4;
    queue_frame(mode_eham_16, -1);
    queue_frame(mode_spc_32, -1);
    run_frames(60000);
  endtask

  initial begin
    ireset     = 1'b1;
    mode       = mode_spc_8;
    in_val     = 1'b0;
    in_dat     = 1'b0;
    out_credit = 1'b0;
    void'($urandom(28));
    test_idle_after_reset();
    test_single_bit();
    test_random_frames();
    test_largest_frame();
    test_back_to_back();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
logic/btc_enc_pkg.sv
logic/btc_enc_comp_code.sv
logic/btc_enc_row_framer.sv
logic/btc_enc_frame_buf.sv
logic/btc_enc_col_sched.sv
logic/btc_enc_top.sv
sim/tb_btc_enc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BTC encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_btc_enc
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_btc_enc 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^Done: no errors$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
